//--- stq_defines.svh
// Sizing macros for the store queue.
// Include this header in every file that builds a port or type from these widths.

`ifndef STQ_DEFINES_SVH
`define STQ_DEFINES_SVH

// number of queue entries; any power of two works.
`define STQ_DEPTH 16

// entry index width, log2 of the depth.
`define STQ_IDX_W 4

// byte address width.
`define STQ_ADDR_W 32

// store data width, four byte lanes.
`define STQ_DATA_W 32

`endif

//--- stq_entry_pkg.sv
// Entry state and queue pointer types for the store queue.
// Pointers carry one wrap bit above the slot index for age and full/empty tests.

`default_nettype none

`include "stq_defines.svh"

package stq_entry_pkg;

  typedef enum logic [1:0] {
    ST_FREE   = 2'd0,
    ST_WAIT   = 2'd1,
    ST_PASSED = 2'd2
  } entry_state_e;

  typedef logic [`STQ_IDX_W:0] stq_idx_t;

  // slot number of a pointer, without the wrap bit.
  function automatic logic [`STQ_IDX_W-1:0] idx_slot(input stq_idx_t p);
    return p[`STQ_IDX_W-1:0];
  endfunction

  function automatic logic [`STQ_DEPTH-1:0] slot_onehot(input stq_idx_t p, input logic en);
    logic [`STQ_DEPTH-1:0] vec;
    vec = '0;
    vec[idx_slot(p)] = en;
    return vec;
  endfunction

  // marks the entries from base up to lim, lim excluded.
  // A lim that has fallen behind base gives an empty window.
  function automatic logic [`STQ_DEPTH-1:0] window_mask(input stq_idx_t base,
                                                        input stq_idx_t lim);
    stq_idx_t              span;
    logic [`STQ_IDX_W-1:0] off;
    logic [`STQ_DEPTH-1:0] mask;
    span = lim - base;
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      off = i[`STQ_IDX_W-1:0] - idx_slot(base);
      mask[i] = (span <= stq_idx_t'(`STQ_DEPTH)) && ({1'b0, off} < span);
    end
    return mask;
  endfunction

endpackage

`default_nettype wire

//--- mem_access_pkg.sv
// Memory access size encoding and byte-lane mask helper.
// Only naturally aligned byte, half and word accesses are described.

`default_nettype none

package mem_access_pkg;

  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } access_size_e;

  // lane mask of an access inside its 32-bit word.
  function automatic logic [3:0] byte_mask(input access_size_e sz, input logic [1:0] lo);
    logic [3:0] mask;
    case (sz)
      SZ_BYTE: begin
        mask = 4'b0001 << lo;
      end
      SZ_HALF: begin
        // a half sits on lanes 0-1 or 2-3, bit 0 is ignored.
        mask = lo[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        mask = 4'b1111;
      end
    endcase
    return mask;
  endfunction

endpackage

`default_nettype wire

//--- stq_addr_array.sv
// Address and state array of the store queue.
// Holds the word address, byte mask and state of each entry and compares
// one load probe against every live entry.

`timescale 1ns/1ps
`default_nettype none

`include "stq_defines.svh"

module stq_addr_array (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  logic [`STQ_DEPTH-1:0]                  alloc_en,
  input  logic [`STQ_DEPTH-1:0]                  pass_en,
  input  logic [`STQ_DEPTH-1:0]                  flush_en,
  input  logic [`STQ_DEPTH-1:0]                  flush_keep,
  input  logic [`STQ_ADDR_W-1:0]                 wrt_addr,
  input  mem_access_pkg::access_size_e           wrt_sz,
  input  logic [`STQ_ADDR_W-1:0]                 chk_addr,
  input  mem_access_pkg::access_size_e           chk_sz,
  output logic [`STQ_DEPTH-1:0]                  overlap,
  output logic [`STQ_DEPTH-1:0]                  covers,
  output logic [`STQ_DEPTH-1:0]                  passed,
  output logic [`STQ_DEPTH-1:0][`STQ_ADDR_W-1:0] entry_addr,
  output logic [`STQ_DEPTH-1:0][3:0]             entry_bytes
);
  import stq_entry_pkg::*;
  import mem_access_pkg::*;

  localparam int WORD_W = `STQ_ADDR_W - 2;

  entry_state_e          state [`STQ_DEPTH];
  logic [WORD_W-1:0]     word  [`STQ_DEPTH];
  logic [3:0]            mask  [`STQ_DEPTH];

  logic [3:0]            wrt_mask;
  logic [3:0]            chk_mask;
  logic [`STQ_DEPTH-1:0] live;
  logic [`STQ_DEPTH-1:0] same_word;

  assign wrt_mask = byte_mask(wrt_sz, wrt_addr[1:0]);
  assign chk_mask = byte_mask(chk_sz, chk_addr[1:0]);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // entry state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // retirement wins over a flush in the same cycle, so the store that
  // commits alongside an exception is kept.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `STQ_DEPTH; i++) begin
        state[i] <= ST_FREE;
      end
    end else begin
      for (int i = 0; i < `STQ_DEPTH; i++) begin
        if (alloc_en[i]) begin
          state[i] <= ST_WAIT;
        end else if (pass_en[i]) begin
          state[i] <= ST_PASSED;
        end else if (flush_en[i] && !flush_keep[i]) begin
          state[i] <= ST_FREE;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      if (alloc_en[i]) begin
        word[i] <= wrt_addr[`STQ_ADDR_W-1:2];
        mask[i] <= wrt_mask;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // probe compare
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar i = 0; i < `STQ_DEPTH; i++) begin : g_cmp
    assign live[i]      = state[i] != ST_FREE;
    assign same_word[i] = word[i] == chk_addr[`STQ_ADDR_W-1:2];

    assign overlap[i] = live[i] && same_word[i] && |(mask[i] & chk_mask);
    // covers means every load lane is supplied by this store.
    assign covers[i]  = live[i] && same_word[i] && ((mask[i] & chk_mask) == chk_mask);
    assign passed[i]  = state[i] == ST_PASSED;

    assign entry_addr[i]  = {word[i], 2'b00};
    assign entry_bytes[i] = mask[i];
  end

endmodule

`default_nettype wire

//--- stq_data_array.sv
// Data array of the store queue.
// Store data arrives by index after allocation; reads are one-hot for
// forwarding and indexed for the drain path.

`timescale 1ns/1ps
`default_nettype none

`include "stq_defines.svh"

module stq_data_array (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  upd_en,
  input  logic [`STQ_IDX_W-1:0] upd_idx,
  input  logic [`STQ_DATA_W-1:0] upd_data,
  input  logic [`STQ_DEPTH-1:0] clr_en,
  input  logic [`STQ_DEPTH-1:0] fwd_sel,
  input  logic [`STQ_IDX_W-1:0] drain_idx,
  output logic [`STQ_DEPTH-1:0] data_valid,
  output logic [`STQ_DATA_W-1:0] fwd_data,
  output logic [`STQ_DATA_W-1:0] drain_data
);

  logic [`STQ_DATA_W-1:0] data [`STQ_DEPTH];
  logic [`STQ_DEPTH-1:0]  upd_dec;

  always_comb begin
    upd_dec = '0;
    upd_dec[upd_idx] = upd_en;
  end

  // a clear beats an update, so a late update to a flushed store is dropped.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_valid <= '0;
    end else begin
      data_valid <= (data_valid | upd_dec) & ~clr_en;
    end
  end

  always_ff @(posedge clk) begin
    if (upd_en) begin
      data[upd_idx] <= upd_data;
    end
  end

  always_comb begin
    fwd_data = '0;
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      if (fwd_sel[i]) begin
        fwd_data = fwd_data | data[i];
      end
    end
  end

  assign drain_data = data[drain_idx];

endmodule

`default_nettype wire

//--- stq_fwd_pick.sv
// Forwarding selector of the store queue.
// Finds the youngest store older than the load that overlaps it and
// decides between a forward hit, a replay, or no match.

`timescale 1ns/1ps
`default_nettype none

`include "stq_defines.svh"

module stq_fwd_pick (
  input  stq_entry_pkg::stq_idx_t head,
  input  stq_entry_pkg::stq_idx_t chk_idx,
  input  logic [`STQ_DEPTH-1:0]   overlap,
  input  logic [`STQ_DEPTH-1:0]   covers,
  input  logic [`STQ_DEPTH-1:0]   data_valid,
  output logic [`STQ_DEPTH-1:0]   fwd_sel,
  output logic                    hit,
  output logic                    replay
);
  import stq_entry_pkg::*;

  localparam int IW = `STQ_IDX_W;

  logic [`STQ_DEPTH-1:0] older;
  logic [`STQ_DEPTH-1:0] cand;
  logic [IW-1:0]         pick_slot;
  logic                  found;

  // only entries from the head up to the load's own tail position count.
  assign older = window_mask(head, chk_idx);
  assign cand  = overlap & older;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // youngest-first search
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // walks backwards from the entry just before chk_idx and wraps around.
  always_comb begin
    logic [IW-1:0] slot;
    found     = 1'b0;
    pick_slot = '0;
    for (int k = 0; k < `STQ_DEPTH; k++) begin
      slot = idx_slot(chk_idx) - IW'(1) - IW'(k);
      if (cand[slot] && !found) begin
        found     = 1'b1;
        pick_slot = slot;
      end
    end
  end

  always_comb begin
    fwd_sel = '0;
    fwd_sel[pick_slot] = found;
  end

  // a hit needs full lane coverage and written data; anything else that
  // overlaps has to wait and replay.
  assign hit    = |(fwd_sel & covers & data_valid);
  assign replay = found && !hit;

endmodule

`default_nettype wire

//--- stq.sv
// Store queue top.
// Allocates stores at the tail, retires them at the commit pointer, drains
// retired stores from the head and answers load probes one cycle later.

`timescale 1ns/1ps
`default_nettype none

`include "stq_defines.svh"

module stq (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          wrt_en,
  input  logic [`STQ_ADDR_W-1:0]        wrt_addr,
  input  mem_access_pkg::access_size_e  wrt_sz,
  output stq_entry_pkg::stq_idx_t       alloc_idx,
  input  logic                          upd_en,
  input  logic [`STQ_IDX_W-1:0]         upd_idx,
  input  logic [`STQ_DATA_W-1:0]        upd_data,
  input  logic                          pse_en,
  input  logic                          excpt,
  input  logic                          chk_en,
  input  logic [`STQ_ADDR_W-1:0]        chk_addr,
  input  mem_access_pkg::access_size_e  chk_sz,
  input  stq_entry_pkg::stq_idx_t       chk_idx,
  output logic                          chk_done,
  output logic                          chk_hit,
  output logic                          chk_replay,
  output logic [`STQ_DATA_W-1:0]        chk_data,
  input  logic                          wb_stall,
  output logic                          wb_en,
  output logic [`STQ_ADDR_W-1:0]        wb_addr,
  output logic [3:0]                    wb_bytes,
  output logic [`STQ_DATA_W-1:0]        wb_data,
  output logic                          stq_full,
  output logic                          stq_empty
);
  import stq_entry_pkg::*;

  stq_idx_t                          head;
  stq_idx_t                          cmt;
  stq_idx_t                          tail;
  stq_idx_t                          cmt_nxt;
  stq_idx_t                          used;
  logic [`STQ_IDX_W-1:0]             head_s;
  logic                              wrt_go;
  logic                              drain_go;

  logic [`STQ_DEPTH-1:0]             alloc_dec;
  logic [`STQ_DEPTH-1:0]             pass_dec;
  logic [`STQ_DEPTH-1:0]             drain_dec;
  logic [`STQ_DEPTH-1:0]             flush_en;
  logic [`STQ_DEPTH-1:0]             flush_keep;
  logic [`STQ_DEPTH-1:0]             free_vec;

  logic [`STQ_DEPTH-1:0]             overlap;
  logic [`STQ_DEPTH-1:0]             covers;
  logic [`STQ_DEPTH-1:0]             passed;
  logic [`STQ_DEPTH-1:0]             data_valid;
  logic [`STQ_DEPTH-1:0]             fwd_sel;
  logic [`STQ_DEPTH-1:0][`STQ_ADDR_W-1:0] entry_addr;
  logic [`STQ_DEPTH-1:0][3:0]        entry_bytes;
  logic [`STQ_DATA_W-1:0]            fwd_data;
  logic [`STQ_DATA_W-1:0]            drain_data;
  logic                              pick_hit;
  logic                              pick_replay;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointers and strobes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign used      = tail - head;
  assign stq_full  = used == stq_idx_t'(`STQ_DEPTH);
  assign stq_empty = used == '0;
  assign alloc_idx = tail;
  assign head_s    = idx_slot(head);

  // an allocation that meets an exception is younger than it and is dropped.
  assign wrt_go   = wrt_en && !stq_full && !excpt;
  assign drain_go = passed[head_s] && data_valid[head_s] && !wb_stall;
  assign cmt_nxt  = cmt + stq_idx_t'(pse_en);

  assign alloc_dec = slot_onehot(tail, wrt_go);
  assign pass_dec  = slot_onehot(cmt, pse_en);
  assign drain_dec = slot_onehot(head, drain_go);

  // on an exception everything goes except the retired stores still waiting to drain.
  assign flush_en   = drain_dec | {`STQ_DEPTH{excpt}};
  assign flush_keep = excpt ? (window_mask(head, cmt_nxt) & ~drain_dec) : '0;
  assign free_vec   = flush_en & ~flush_keep;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      head <= '0;
      cmt  <= '0;
      tail <= '0;
    end else begin
      head <= head + stq_idx_t'(drain_go);
      cmt  <= cmt_nxt;
      if (excpt) begin
        tail <= cmt_nxt;
      end else begin
        tail <= tail + stq_idx_t'(wrt_go);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // arrays and forwarding
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  stq_addr_array i_addr (
    .clk         (clk),
    .arst_n      (arst_n),
    .alloc_en    (alloc_dec),
    .pass_en     (pass_dec),
    .flush_en    (flush_en),
    .flush_keep  (flush_keep),
    .wrt_addr    (wrt_addr),
    .wrt_sz      (wrt_sz),
    .chk_addr    (chk_addr),
    .chk_sz      (chk_sz),
    .overlap     (overlap),
    .covers      (covers),
    .passed      (passed),
    .entry_addr  (entry_addr),
    .entry_bytes (entry_bytes)
  );

  // a fresh allocation also clears the flag, so stale data never forwards.
  stq_data_array i_data (
    .clk        (clk),
    .arst_n     (arst_n),
    .upd_en     (upd_en),
    .upd_idx    (upd_idx),
    .upd_data   (upd_data),
    .clr_en     (free_vec | alloc_dec),
    .fwd_sel    (fwd_sel),
    .drain_idx  (head_s),
    .data_valid (data_valid),
    .fwd_data   (fwd_data),
    .drain_data (drain_data)
  );

  stq_fwd_pick i_pick (
    .head       (head),
    .chk_idx    (chk_idx),
    .overlap    (overlap),
    .covers     (covers),
    .data_valid (data_valid),
    .fwd_sel    (fwd_sel),
    .hit        (pick_hit),
    .replay     (pick_replay)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // registered outputs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      chk_done   <= 1'b0;
      chk_hit    <= 1'b0;
      chk_replay <= 1'b0;
      wb_en      <= 1'b0;
    end else begin
      chk_done   <= chk_en;
      chk_hit    <= chk_en && pick_hit;
      chk_replay <= chk_en && pick_replay;
      wb_en      <= drain_go;
    end
  end

  always_ff @(posedge clk) begin
    if (chk_en) begin
      chk_data <= fwd_data;
    end
    if (drain_go) begin
      wb_addr  <= entry_addr[head_s];
      wb_bytes <= entry_bytes[head_s];
      wb_data  <= drain_data;
    end
  end

endmodule

`default_nettype wire

//--- tb_clkgen.sv
// Clock and reset source for the store queue testbench.
// Reset is held low for a fixed number of rising edges, then released.

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter real PERIOD_NS  = 4.0,
  parameter int  RST_CYCLES = 16
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #0.5 arst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- stq_tb.sv
// Testbench for the store queue.
// A slot-level model predicts probe answers and the drain order; immediate
// assertions at the falling edge compare the DUT against it.

`timescale 1ns/1ps
`default_nettype none

`include "stq_defines.svh"

module stq_tb;
  import stq_entry_pkg::*;
  import mem_access_pkg::*;

  // well above the length of the directed and random traffic.
  localparam int MAX_CYCLES = 3000;

  logic clk, arst_n;
  logic wrt_en, upd_en, pse_en, excpt, chk_en, wb_stall;
  logic [31:0] wrt_addr, upd_data, chk_addr;
  access_size_e wrt_sz, chk_sz;
  logic [3:0] upd_idx;
  stq_idx_t alloc_idx, chk_idx;
  logic chk_done, chk_hit, chk_replay, wb_en, stq_full, stq_empty;
  logic [31:0] chk_data, wb_addr, wb_data;
  logic [3:0] wb_bytes;

  // model of every slot plus the three pointers.
  entry_state_e m_state [16];
  logic [29:0] m_word [16];
  logic [3:0] m_mask [16];
  logic m_valid [16];
  logic [31:0] m_data [16];
  stq_idx_t m_head, m_cmt, m_tail;

  logic exp_wb, probe_due, exp_hit, exp_replay;
  logic [31:0] exp_addr, exp_data, exp_fwd;
  logic [3:0] exp_bytes;
  int cycles;

  tb_clkgen #(.PERIOD_NS(4.0), .RST_CYCLES(16)) i_clkgen (.clk(clk), .arst_n(arst_n));

  stq i_dut (
    .clk(clk), .arst_n(arst_n), .wrt_en(wrt_en), .wrt_addr(wrt_addr), .wrt_sz(wrt_sz),
    .alloc_idx(alloc_idx), .upd_en(upd_en), .upd_idx(upd_idx), .upd_data(upd_data),
    .pse_en(pse_en), .excpt(excpt), .chk_en(chk_en), .chk_addr(chk_addr),
    .chk_sz(chk_sz), .chk_idx(chk_idx), .chk_done(chk_done), .chk_hit(chk_hit),
    .chk_replay(chk_replay), .chk_data(chk_data), .wb_stall(wb_stall), .wb_en(wb_en),
    .wb_addr(wb_addr), .wb_bytes(wb_bytes), .wb_data(wb_data), .stq_full(stq_full),
    .stq_empty(stq_empty)
  );

  task automatic abort(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    abort($sformatf("[FAIL] %s expected %h got %h", name, exp, got));
  endtask

  // lane mask as the access-size rules define it.
  function automatic logic [3:0] lane_mask(input access_size_e sz, input logic [1:0] lo);
    if (sz == SZ_BYTE) return 4'b0001 << lo;
    if (sz == SZ_HALF) return lo[1] ? 4'b1100 : 4'b0011;
    return 4'b1111;
  endfunction

  function automatic stq_idx_t used_count();
    return m_tail - m_head;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // model drain, timeout and checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin : drain_model
    logic [3:0] hs;
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) abort("timeout: the run did not finish within the cycle limit");
    hs = m_head[3:0];
    exp_wb = 1'b0;
    if (arst_n && m_head != m_tail && m_state[hs] == ST_PASSED && m_valid[hs] && !wb_stall) begin
      exp_wb = 1'b1;
      exp_addr = {m_word[hs], 2'b00};
      exp_bytes = m_mask[hs];
      exp_data = m_data[hs];
      m_state[hs] = ST_FREE;
      m_valid[hs] = 1'b0;
      m_head = m_head + 1'b1;
    end
  end

  always @(negedge clk) begin
    if (arst_n) begin
      assert (wb_en === exp_wb) else fail_value("wb_en", exp_wb, wb_en);
      if (exp_wb) begin
        assert (wb_addr === exp_addr) else fail_value("wb_addr", exp_addr, wb_addr);
        assert (wb_bytes === exp_bytes) else fail_value("wb_bytes", exp_bytes, wb_bytes);
        assert (wb_data === exp_data) else fail_value("wb_data", exp_data, wb_data);
      end
      assert (chk_done === probe_due) else fail_value("chk_done", probe_due, chk_done);
      if (probe_due) begin
        assert (chk_hit === exp_hit) else fail_value("chk_hit", exp_hit, chk_hit);
        assert (chk_replay === exp_replay) else fail_value("chk_replay", exp_replay, chk_replay);
        if (exp_hit) begin
          assert (chk_data === exp_fwd) else fail_value("chk_data", exp_fwd, chk_data);
        end
      end
      assert (stq_empty === (used_count() == 0))
        else fail_value("stq_empty", used_count() == 0, stq_empty);
      assert (stq_full === (used_count() == 16))
        else fail_value("stq_full", used_count() == 16, stq_full);
      assert (alloc_idx === m_tail) else fail_value("alloc_idx", m_tail, alloc_idx);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // each task starts and ends 0.5 ns after a rising edge.
  task automatic idle(input int n);
    repeat (n) @(posedge clk);
    #0.5;
  endtask

  task automatic alloc_store(input logic [31:0] a, input access_size_e sz, output stq_idx_t idx);
    logic accept;
    accept = used_count() != 16;
    idx = m_tail;
    wrt_en = 1'b1;
    wrt_addr = a;
    wrt_sz = sz;
    idle(1);
    wrt_en = 1'b0;
    if (accept) begin
      m_state[idx[3:0]] = ST_WAIT;
      m_word[idx[3:0]] = a[31:2];
      m_mask[idx[3:0]] = lane_mask(sz, a[1:0]);
      m_valid[idx[3:0]] = 1'b0;
      m_tail = m_tail + 1'b1;
    end
  endtask

  task automatic write_data(input logic [3:0] slot, input logic [31:0] d);
    upd_en = 1'b1;
    upd_idx = slot;
    upd_data = d;
    idle(1);
    upd_en = 1'b0;
    m_valid[slot] = 1'b1;
    m_data[slot] = d;
  endtask

  task automatic retire_store();
    pse_en = 1'b1;
    idle(1);
    pse_en = 1'b0;
    m_state[m_cmt[3:0]] = ST_PASSED;
    m_cmt = m_cmt + 1'b1;
  endtask

  task automatic raise_exception();
    excpt = 1'b1;
    idle(1);
    excpt = 1'b0;
    for (stq_idx_t p = m_cmt; p != m_tail; p++) begin
      m_state[p[3:0]] = ST_FREE;
      m_valid[p[3:0]] = 1'b0;
    end
    m_tail = m_cmt;
  endtask

  // the youngest overlapping store older than idx decides the answer.
  task automatic probe_load(input logic [31:0] a, input access_size_e sz, input stq_idx_t idx);
    stq_idx_t span, p;
    logic [3:0] lm;
    exp_hit = 1'b0;
    exp_replay = 1'b0;
    lm = lane_mask(sz, a[1:0]);
    span = idx - m_head;
    for (int k = 1; k <= 16; k++) begin
      p = idx - k[4:0];
      if (k <= span && span <= 16 && !exp_hit && !exp_replay && m_state[p[3:0]] != ST_FREE
          && m_word[p[3:0]] == a[31:2] && |(m_mask[p[3:0]] & lm)) begin
        exp_hit = ((m_mask[p[3:0]] & lm) == lm) && m_valid[p[3:0]];
        exp_replay = !exp_hit;
        exp_fwd = m_data[p[3:0]];
      end
    end
    chk_en = 1'b1;
    chk_addr = a;
    chk_sz = sz;
    chk_idx = idx;
    idle(1);
    chk_en = 1'b0;
    probe_due = 1'b1;
    idle(1);
    probe_due = 1'b0;
  endtask

  task automatic rand_access(output logic [31:0] a, output access_size_e sz);
    sz = access_size_e'($urandom % 3);
    a = 32'h40 + 32'(($urandom % 4) * 4);
    if (sz == SZ_BYTE) a[1:0] = 2'($urandom);
    if (sz == SZ_HALF) a[1] = 1'($urandom);
  endtask

  initial begin
    stq_idx_t i0, i1, i2, ic;
    logic [31:0] a;
    access_size_e sz;
    void'($urandom(89389));
    {wrt_en, upd_en, pse_en, excpt, chk_en, wb_stall} = '0;
    {wrt_addr, upd_data, chk_addr, upd_idx, chk_idx} = '0;
    wrt_sz = SZ_WORD;
    chk_sz = SZ_WORD;
    {m_head, m_cmt, m_tail, exp_wb, probe_due, exp_hit, exp_replay} = '0;
    cycles = 0;
    for (int s = 0; s < 16; s++) begin
      m_state[s] = ST_FREE;
      m_valid[s] = 1'b0;
    end
    wait (arst_n === 1'b1);
    idle(1);
    // fill to full, try one more, then flush everything.
    for (int s = 0; s <= 16; s++) alloc_store(32'h1000 + 32'(s * 4), SZ_WORD, i0);
    raise_exception();
    alloc_store(32'h100, SZ_WORD, i0);
    write_data(i0[3:0], 32'hcafe_0100);
    probe_load(32'h100, SZ_WORD, m_tail);
    probe_load(32'h102, SZ_BYTE, m_tail);
    alloc_store(32'h201, SZ_BYTE, i1);
    write_data(i1[3:0], 32'h0000_ab00);
    probe_load(32'h200, SZ_WORD, m_tail);
    alloc_store(32'h300, SZ_WORD, ic);
    probe_load(32'h300, SZ_WORD, m_tail);
    probe_load(32'h400, SZ_WORD, m_tail);
    alloc_store(32'h500, SZ_WORD, i1);
    write_data(i1[3:0], 32'h1111_5001);
    alloc_store(32'h500, SZ_WORD, i2);
    write_data(i2[3:0], 32'h2222_5002);
    probe_load(32'h500, SZ_WORD, m_tail);
    probe_load(32'h500, SZ_HALF, i2);
    probe_load(32'h500, SZ_WORD, i1);
    // drain: held by the stall, then by the missing data at 0x300.
    wb_stall = 1'b1;
    while (m_cmt != m_tail) retire_store();
    idle(4);
    wb_stall = 1'b0;
    idle(6);
    write_data(ic[3:0], 32'h3333_0300);
    idle(6);
    // exception with one retired store waiting behind a stall.
    for (int s = 0; s < 3; s++) begin
      alloc_store(32'h600 + 32'(s * 4), SZ_WORD, i0);
      write_data(i0[3:0], $urandom);
    end
    retire_store();
    wb_stall = 1'b1;
    raise_exception();
    probe_load(32'h604, SZ_WORD, m_tail);
    wb_stall = 1'b0;
    idle(4);
    for (int r = 0; r < 20; r++) begin
      repeat (1 + $urandom % 3) begin
        rand_access(a, sz);
        alloc_store(a, sz, i0);
        if ($urandom % 2) write_data(i0[3:0], $urandom);
      end
      rand_access(a, sz);
      probe_load(a, sz, m_tail);
      for (stq_idx_t p = m_head; p != m_tail; p++) begin
        if (!m_valid[p[3:0]] && $urandom % 2) write_data(p[3:0], $urandom);
      end
      if (m_cmt != m_tail && $urandom % 3 != 0) retire_store();
      wb_stall = ($urandom % 4) == 0;
      if (r % 7 == 3) raise_exception();
    end
    wb_stall = 1'b0;
    for (stq_idx_t p = m_head; p != m_tail; p++) begin
      if (!m_valid[p[3:0]]) write_data(p[3:0], $urandom);
    end
    while (m_cmt != m_tail) retire_store();
    while (m_head != m_tail) idle(1);
    idle(3);
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
stq_entry_pkg.sv
mem_access_pkg.sv
stq_addr_array.sv
stq_data_array.sv
stq_fwd_pick.sv
stq.sv
tb_clkgen.sv
stq_tb.sv
